// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_branch_predictor
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, result decided from $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== compile.f ====
+incdir+dv
source/bp_pkg.sv
source/global_hist_predictor.sv
source/local_hist_predictor.sv
source/pred_chooser.sv
source/branch_predictor.sv
dv/tb_branch_predictor.sv

// ==== dv/bp_ref_model.svh ====
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// Behavioral copy of every table and history starting from the reset state
logic [31:0]          mdl_pc_q          = '0;
logic [GHIST_LEN-1:0] mdl_ghist         = '0;
logic [GHIST_LEN-1:0] mdl_ghist_commit  = '0;
logic [1:0]           mdl_gpht   [4096] = '{default: '0};
logic                 mdl_gvalid [4096] = '{default: '0};
logic [LHIST_LEN-1:0] mdl_bht    [1024] = '{default: '0};
logic                 mdl_bvalid [1024] = '{default: '0};
logic [1:0]           mdl_lpht   [1024] = '{default: '0};
logic                 mdl_lvalid [1024] = '{default: '0};
logic [1:0]           mdl_choice [1024] = '{default: '0};

// Expected outputs for the pc held in the stage
bp_tag_t exp_tag;
logic    exp_valid;
logic    exp_taken;

function automatic logic [1:0] saturate_step(input logic [1:0] ctr, input logic up);
    if (up) begin
        return (ctr == 2'd3) ? ctr : ctr + 2'd1;
    end
    return (ctr == 2'd0) ? ctr : ctr - 2'd1;
endfunction

function automatic void predict();
    exp_tag.gidx    = mdl_pc_q[13:2] ^ 12'(mdl_ghist);
    exp_tag.bidx    = mdl_pc_q[11:2];
    exp_tag.lidx    = 10'(mdl_bht[exp_tag.bidx]);
    exp_tag.g_valid = mdl_gvalid[exp_tag.gidx];
    exp_tag.g_taken = mdl_gpht[exp_tag.gidx][1];
    exp_tag.l_valid = mdl_bvalid[exp_tag.bidx] & mdl_lvalid[exp_tag.lidx];
    exp_tag.l_taken = mdl_lpht[exp_tag.lidx][1];
    exp_valid       = exp_tag.g_valid | exp_tag.l_valid;
    if (exp_tag.g_valid && exp_tag.l_valid) begin
        exp_taken = mdl_choice[exp_tag.bidx][1] ? exp_tag.g_taken : exp_tag.l_taken;
    end else if (exp_tag.g_valid) begin
        exp_taken = exp_tag.g_taken;
    end else begin
        exp_taken = exp_tag.l_valid & exp_tag.l_taken;
    end
endfunction

// One rising edge with the inputs driven for it
function automatic void advance_state(input logic hold, input logic rec, input logic [31:0] pc,
                                      input logic cmt, input bp_tag_t tag, input logic taken);
    // Recover takes the committed history from before this edge
    if (rec) begin
        mdl_ghist = mdl_ghist_commit;
    end else if (exp_valid && !hold) begin
        mdl_ghist = GHIST_LEN'({mdl_ghist, exp_taken});
    end
    if (cmt) begin
        mdl_ghist_commit     = GHIST_LEN'({mdl_ghist_commit, taken});
        mdl_gpht[tag.gidx]   = saturate_step(mdl_gpht[tag.gidx], taken);
        mdl_gvalid[tag.gidx] = 1'b1;
        mdl_bht[tag.bidx]    = LHIST_LEN'({mdl_bht[tag.bidx], taken});
        mdl_bvalid[tag.bidx] = 1'b1;
        mdl_lpht[tag.lidx]   = saturate_step(mdl_lpht[tag.lidx], taken);
        mdl_lvalid[tag.lidx] = 1'b1;
        // Chooser only learns from a disagreement
        if (tag.g_valid && tag.l_valid && (tag.g_taken != tag.l_taken)) begin
            mdl_choice[tag.bidx] = saturate_step(mdl_choice[tag.bidx], tag.g_taken == taken);
        end
    end
    if (!hold) begin
        mdl_pc_q = pc;
    end
endfunction

`endif

// ==== dv/tb_branch_predictor.sv ====
`timescale 1ns/1ps

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int GHIST_LEN    = 12;
    localparam int LHIST_LEN    = 10;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 40;
    localparam int RAND_CYCLES  = 4000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + RAND_CYCLES;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 pause;
    logic                 recover;
    logic                 commit;
    logic                 commit_taken;
    logic                 pred_valid;
    logic                 pred_taken;
    logic [31:0]          br_pc;
    bp_tag_t              pred_tag;
    bp_tag_t              commit_tag;
    logic [GHIST_LEN-1:0] ghist;

    integer      seed = 32'heb00ba8e;
    logic [31:0] pool_pc   [16];
    int          pool_rule [16];
    int          pool_seen [16];
    int          q_br = -1;
    bp_tag_t     tag_q     [$];
    logic        taken_q   [$];

    `include "bp_ref_model.svh"

    branch_predictor #(
        .GHIST_LEN (GHIST_LEN),
        .LHIST_LEN (LHIST_LEN)
    ) DUT (.*);

    always #4 clk = ~clk;

    // Watchdog sized from the number of test cycles
    initial begin
        #(TOTAL_CYCLES * 8 + 400);
        $display("timeout before tests finished");
        $display("sim failed");
        $fatal(1);
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs();
        predict();
        check_val("pred_valid", pred_valid, exp_valid);
        check_val("pred_taken", pred_taken, exp_taken);
        check_val("pred_tag.gidx", pred_tag.gidx, exp_tag.gidx);
        check_val("pred_tag.bidx", pred_tag.bidx, exp_tag.bidx);
        check_val("pred_tag.lidx", pred_tag.lidx, exp_tag.lidx);
        check_val("pred_tag.g_valid", pred_tag.g_valid, exp_tag.g_valid);
        check_val("pred_tag.g_taken", pred_tag.g_taken, exp_tag.g_taken);
        check_val("pred_tag.l_valid", pred_tag.l_valid, exp_tag.l_valid);
        check_val("pred_tag.l_taken", pred_tag.l_taken, exp_tag.l_taken);
        check_val("ghist", ghist, mdl_ghist);
    endtask

    // Always, never, alternating, every third time
    function automatic logic branch_outcome(input int rule, input int n);
        case (rule)
            0:       return 1'b1;
            1:       return 1'b0;
            2:       return n[0];
            default: return (n % 3) == 2;
        endcase
    endfunction

    task automatic run_cycle(input int commit_pct, input int pause_pct, input int recover_pct);
        int br_n;
        @(negedge clk);
        compare_outputs();
        br_n         = {$random(seed)} % 16;
        pause        = ({$random(seed)} % 100) < pause_pct;
        recover      = ({$random(seed)} % 100) < recover_pct;
        br_pc        = pool_pc[br_n];
        commit       = 1'b0;
        commit_tag   = '0;
        commit_taken = 1'b0;
        if (tag_q.size() > 0 && ({$random(seed)} % 100) < commit_pct) begin
            commit       = 1'b1;
            commit_tag   = tag_q.pop_front();
            commit_taken = taken_q.pop_front();
        end
        // Squash everything still in flight
        if (recover) begin
            tag_q.delete();
            taken_q.delete();
        end else if (!pause && q_br >= 0) begin
            tag_q.push_back(pred_tag);
            taken_q.push_back(branch_outcome(pool_rule[q_br], pool_seen[q_br]));
            pool_seen[q_br]++;
        end
        advance_state(pause, recover, br_pc, commit, commit_tag, commit_taken);
        if (!pause) begin
            q_br = br_n;
        end
    endtask

    initial begin
        rst          = 1'b1;
        pause        = 1'b0;
        recover      = 1'b0;
        br_pc        = '0;
        commit       = 1'b0;
        commit_tag   = '0;
        commit_taken = 1'b0;
        // Few pc bits vary, so slots and counters alias
        for (int i = 0; i < 16; i++) begin
            pool_pc[i]   = 32'h0040_0000 | ($random(seed) & 32'h0000_30fc);
            pool_rule[i] = i % 4;
            pool_seen[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        predict();
        advance_state(pause, recover, br_pc, commit, commit_tag, commit_taken);
        // Nothing committed yet
        repeat (IDLE_CYCLES) begin
            run_cycle(0, 20, 0);
            check_val("pred_valid", pred_valid, 1'b0);
            check_val("ghist", ghist, '0);
        end
        repeat (RAND_CYCLES) begin
            run_cycle(60, 15, 3);
        end
        $display("sim passed");
        $finish;
    end

endmodule

// ==== source/bp_pkg.sv ====
package bp_pkg;

    // Table geometry
    localparam int GPHT_IDX_W = 12;
    localparam int BHT_IDX_W  = 10;
    localparam int LPHT_IDX_W = 10;

    // 2-bit saturating counter whose upper bit is the vote
    typedef logic [1:0] bp_ctr_t;

    // Opaque token carried from prediction to commit
    typedef struct packed {
        logic [GPHT_IDX_W-1:0] gidx;
        logic [BHT_IDX_W-1:0]  bidx;
        logic [LPHT_IDX_W-1:0] lidx;
        logic                  g_valid;
        logic                  g_taken;
        logic                  l_valid;
        logic                  l_taken;
    } bp_tag_t;

    // One saturating step up or down
    function automatic bp_ctr_t ctr_step(bp_ctr_t ctr, logic up);
        bp_ctr_t next;
        if (up) begin
            next = (ctr == 2'b11) ? ctr : ctr + 2'b01;
        end else begin
            next = (ctr == 2'b00) ? ctr : ctr - 2'b01;
        end
        return next;
    endfunction

endpackage

// ==== source/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor #(
    parameter int GHIST_LEN = 12,
    parameter int LHIST_LEN = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pause,
    input  logic                 recover,
    input  logic [31:0]          br_pc,
    output logic                 pred_valid,
    output logic                 pred_taken,
    output bp_pkg::bp_tag_t      pred_tag,
    output logic [GHIST_LEN-1:0] ghist,
    input  logic                 commit,
    input  bp_pkg::bp_tag_t      commit_tag,
    input  logic                 commit_taken
);
    import bp_pkg::*;

    logic [31:0]           pc_q;
    logic [GPHT_IDX_W-1:0] gidx;
    logic [BHT_IDX_W-1:0]  bidx;
    logic [LPHT_IDX_W-1:0] lidx;
    logic                  g_valid;
    logic                  g_taken;
    logic                  l_valid;
    logic                  l_taken;

    // Final prediction also feeds the speculative global history
    pred_chooser u_chooser (
        .clk          (clk),
        .rst          (rst),
        .pause        (pause),
        .br_pc        (br_pc),
        .pc_q         (pc_q),
        .g_valid      (g_valid),
        .g_taken      (g_taken),
        .l_valid      (l_valid),
        .l_taken      (l_taken),
        .gidx         (gidx),
        .bidx         (bidx),
        .lidx         (lidx),
        .commit       (commit),
        .commit_tag   (commit_tag),
        .commit_taken (commit_taken),
        .spec_valid   (pred_valid),
        .spec_taken   (pred_taken),
        .pred_tag     (pred_tag)
    );

    global_hist_predictor #(
        .GHIST_LEN (GHIST_LEN)
    ) u_global (
        .clk          (clk),
        .rst          (rst),
        .recover      (recover),
        .pause        (pause),
        .pc_q         (pc_q),
        .spec_valid   (pred_valid),
        .spec_taken   (pred_taken),
        .commit       (commit),
        .commit_tag   (commit_tag),
        .commit_taken (commit_taken),
        .gidx         (gidx),
        .g_valid      (g_valid),
        .g_taken      (g_taken),
        .ghist        (ghist)
    );

    local_hist_predictor #(
        .LHIST_LEN (LHIST_LEN)
    ) u_local (
        .clk          (clk),
        .rst          (rst),
        .pc_q         (pc_q),
        .commit       (commit),
        .commit_tag   (commit_tag),
        .commit_taken (commit_taken),
        .bidx         (bidx),
        .lidx         (lidx),
        .l_valid      (l_valid),
        .l_taken      (l_taken)
    );

endmodule

// ==== source/global_hist_predictor.sv ====
`timescale 1ns/1ps

module global_hist_predictor #(
    parameter int GHIST_LEN = 12
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          recover,
    input  logic                          pause,
    input  logic [31:0]                   pc_q,
    input  logic                          spec_valid,
    input  logic                          spec_taken,
    input  logic                          commit,
    input  bp_pkg::bp_tag_t               commit_tag,
    input  logic                          commit_taken,
    output logic [bp_pkg::GPHT_IDX_W-1:0] gidx,
    output logic                          g_valid,
    output logic                          g_taken,
    output logic [GHIST_LEN-1:0]          ghist
);
    import bp_pkg::*;

    localparam int GPHT_DEPTH = 2 ** GPHT_IDX_W;

    logic [GHIST_LEN-1:0]  ghist_commit;
    bp_ctr_t               gpht [GPHT_DEPTH];
    logic [GPHT_DEPTH-1:0] gpht_valid;
    bp_ctr_t               gpht_cur;
    bp_ctr_t               gpht_upd;

    // gshare index from the registered pc and speculative history
    assign gidx     = pc_q[GPHT_IDX_W+1:2] ^ GPHT_IDX_W'(ghist);
    assign gpht_cur = gpht[gidx];
    assign g_taken  = gpht_cur[1];
    assign g_valid  = gpht_valid[gidx];

    // Speculative history rolls back to the committed copy on recover
    always_ff @(posedge clk) begin
        if (rst) begin
            ghist <= '0;
        end else if (recover) begin
            ghist <= ghist_commit;
        end else if (spec_valid && !pause) begin
            ghist <= GHIST_LEN'({ghist, spec_taken});
        end
    end

    // Committed history
    always_ff @(posedge clk) begin
        if (rst) begin
            ghist_commit <= '0;
        end else if (commit) begin
            ghist_commit <= GHIST_LEN'({ghist_commit, commit_taken});
        end
    end

    assign gpht_upd = ctr_step(gpht[commit_tag.gidx], commit_taken);

    // Train the counter named in the tag
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < GPHT_DEPTH; i++) begin
                gpht[i] <= '0;
            end
            gpht_valid <= '0;
        end else if (commit) begin
            gpht[commit_tag.gidx]       <= gpht_upd;
            gpht_valid[commit_tag.gidx] <= 1'b1;
        end
    end

endmodule

// ==== source/local_hist_predictor.sv ====
`timescale 1ns/1ps

module local_hist_predictor #(
    parameter int LHIST_LEN = 10
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [31:0]                   pc_q,
    input  logic                          commit,
    input  bp_pkg::bp_tag_t               commit_tag,
    input  logic                          commit_taken,
    output logic [bp_pkg::BHT_IDX_W-1:0]  bidx,
    output logic [bp_pkg::LPHT_IDX_W-1:0] lidx,
    output logic                          l_valid,
    output logic                          l_taken
);
    import bp_pkg::*;

    localparam int BHT_DEPTH  = 2 ** BHT_IDX_W;
    localparam int LPHT_DEPTH = 2 ** LPHT_IDX_W;

    logic [LHIST_LEN-1:0]  bht [BHT_DEPTH];
    logic [BHT_DEPTH-1:0]  bht_valid;
    bp_ctr_t               lpht [LPHT_DEPTH];
    logic [LPHT_DEPTH-1:0] lpht_valid;
    bp_ctr_t               lpht_cur;
    bp_ctr_t               lpht_upd;
    logic [LHIST_LEN-1:0]  hist_upd;

    // Slot from pc, then the slot's own history picks the counter
    assign bidx     = pc_q[BHT_IDX_W+1:2];
    assign lidx     = LPHT_IDX_W'(bht[bidx]);
    assign lpht_cur = lpht[lidx];
    assign l_taken  = lpht_cur[1];
    assign l_valid  = bht_valid[bidx] & lpht_valid[lidx];

    assign hist_upd = LHIST_LEN'({bht[commit_tag.bidx], commit_taken});
    assign lpht_upd = ctr_step(lpht[commit_tag.lidx], commit_taken);

    // Per-branch history table
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_DEPTH; i++) begin
                bht[i] <= '0;
            end
            bht_valid <= '0;
        end else if (commit) begin
            bht[commit_tag.bidx]       <= hist_upd;
            bht_valid[commit_tag.bidx] <= 1'b1;
        end
    end

    // Local counters train at the index used for the prediction
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LPHT_DEPTH; i++) begin
                lpht[i] <= '0;
            end
            lpht_valid <= '0;
        end else if (commit) begin
            lpht[commit_tag.lidx]       <= lpht_upd;
            lpht_valid[commit_tag.lidx] <= 1'b1;
        end
    end

endmodule

// ==== source/pred_chooser.sv ====
`timescale 1ns/1ps

module pred_chooser (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pause,
    input  logic [31:0]                   br_pc,
    output logic [31:0]                   pc_q,
    input  logic                          g_valid,
    input  logic                          g_taken,
    input  logic                          l_valid,
    input  logic                          l_taken,
    input  logic [bp_pkg::GPHT_IDX_W-1:0] gidx,
    input  logic [bp_pkg::BHT_IDX_W-1:0]  bidx,
    input  logic [bp_pkg::LPHT_IDX_W-1:0] lidx,
    input  logic                          commit,
    input  bp_pkg::bp_tag_t               commit_tag,
    input  logic                          commit_taken,
    output logic                          spec_valid,
    output logic                          spec_taken,
    output bp_pkg::bp_tag_t               pred_tag
);
    import bp_pkg::*;

    localparam int CH_DEPTH = 2 ** BHT_IDX_W;

    bp_ctr_t chooser [CH_DEPTH];
    bp_ctr_t ch_cur;
    logic    use_global;
    logic    train_ch;
    logic    global_right;

    // Single stall register of the prediction stage
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (!pause) begin
            pc_q <= br_pc;
        end
    end

    // Global wins when it is the only one valid, or the chooser prefers it
    assign ch_cur     = chooser[bidx];
    assign use_global = g_valid & (~l_valid | ch_cur[1]);
    assign spec_valid = g_valid | l_valid;
    assign spec_taken = use_global ? g_taken : (l_valid & l_taken);

    always_comb begin
        pred_tag.gidx    = gidx;
        pred_tag.bidx    = bidx;
        pred_tag.lidx    = lidx;
        pred_tag.g_valid = g_valid;
        pred_tag.g_taken = g_taken;
        pred_tag.l_valid = l_valid;
        pred_tag.l_taken = l_taken;
    end

    // Only train when both components voted and disagreed
    assign train_ch = commit & commit_tag.g_valid & commit_tag.l_valid
                      & (commit_tag.g_taken ^ commit_tag.l_taken);
    assign global_right = (commit_tag.g_taken == commit_taken);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CH_DEPTH; i++) begin
                chooser[i] <= '0;
            end
        end else if (train_ch) begin
            chooser[commit_tag.bidx] <= ctr_step(chooser[commit_tag.bidx], global_right);
        end
    end

endmodule
